//--- memSystem.f
+incdir+.
cachePkg.sv
memPkg.sv
cacheWay.sv
cacheCtrl.sv
bankedMem.sv
memSystem.sv
memSystem_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module memSystem_tb -f memSystem.f \
	&& ./obj_dir/VmemSystem_tb > sim.log 2>&1 \
	|| echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

//--- memSystem_vectors.txt
# write addr wdata expRdata expHit expErr, all hex
# expRdata is only checked on reads that return no error
0 0010 0000 0010 0 0
0 0010 0000 0010 1 0
0 0016 0000 0016 1 0
1 0012 a5a5 0000 1 0
0 0012 0000 a5a5 1 0
1 0024 1234 0000 0 0
0 0020 0000 0020 1 0
0 0026 0000 0026 1 0
0 0024 0000 1234 1 0
0 0040 0000 0040 0 0
1 0842 beef 0000 0 0
0 0040 0000 0040 1 0
0 1040 0000 1040 0 0
0 0840 0000 0840 0 0
0 0842 0000 beef 1 0
0 1040 0000 1040 1 0
0 0040 0000 0040 0 0
0 1840 0000 1840 0 0
0 1040 0000 1040 0 0
1 1846 7777 0000 1 0
0 0846 0000 0846 0 0
0 0046 0000 0046 0 0
0 1846 0000 7777 0 0
0 0011 0000 0000 0 1
0 0010 0000 0010 1 0
1 0013 ffff 0000 0 1
0 0012 0000 a5a5 1 0

//--- memSystem_tb.sv
`timescale 1ns/1ns

module memSystem_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int CYCLES_PER_VEC = 40;
	localparam int DRIVE_DELAY = 1;

	typedef struct packed {
		logic write;
		cachePkg::addr_t addr;
		cachePkg::word_t wdata;
		cachePkg::word_t expRdata;
		logic expHit;
		logic expErr;
	} vecLine_t;

	// An accepted request still waiting for its response
	typedef struct packed {
		vecLine_t vec;
		int idx;
		int acceptCyc;
	} pending_t;

	logic clk;
	logic rstN;
	logic reqValid;
	logic reqReady;
	cachePkg::cpuReq_t req;
	logic rspValid;
	cachePkg::cpuRsp_t rsp;

	vecLine_t vecQ[$];
	pending_t pendQ[$];
	int errCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int timeoutLimit = 0;
	int acceptCount = 0;
	int rspCount = 0;

	memSystem i_dut (
		.clk      (clk),
		.rstN     (rstN),
		.reqValid (reqValid),
		.reqReady (reqReady),
		.req      (req),
		.rspValid (rspValid),
		.rsp      (rsp)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
			$display("timeout: the run did not finish within %0d cycles", timeoutLimit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errCount++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Matches a response against the oldest accepted request
	task automatic checkResponse();
		pending_t p;
		int lat;
		string tag;
		if (pendQ.size() == 0) begin
			errCount++;
			$display("a response came at %0t ns with no request outstanding", $time);
			return;
		end
		p = pendQ.pop_front();
		lat = cycleCount - p.acceptCyc;
		tag = $sformatf("vector %0d", p.idx);
		compareValue({tag, " rsp.err"}, rsp.err, p.vec.expErr);
		compareValue({tag, " rsp.hit"}, rsp.hit, p.vec.expHit);
		if (!p.vec.write && !p.vec.expErr) begin
			compareValue({tag, " rsp.rdata"}, rsp.rdata, p.vec.expRdata);
		end
		// One cycle for an error, two for a hit, a miss has no fixed latency
		if (p.vec.expErr) begin
			compareValue({tag, " latency"}, lat, 1);
		end else if (p.vec.expHit) begin
			compareValue({tag, " latency"}, lat, 2);
		end
	endtask

	// Mid-cycle, so handshakes are seen once they have settled
	always @(negedge clk) begin
		if (rstN && reqValid && reqReady) begin
			acceptCount++;
		end
		if (rstN && rspValid) begin
			rspCount++;
			checkResponse();
		end
	end

	task automatic loadVectors();
		int fd;
		int n;
		string line;
		vecLine_t v;
		logic [31:0] fWrite, fAddr, fWdata, fRdata, fHit, fErr;
		fd = $fopen("memSystem_vectors.txt", "r");
		if (fd == 0) begin
			errCount++;
			$display("could not open the vector file memSystem_vectors.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
				continue;  // Comment or blank line
			end
			n = $sscanf(line, "%h %h %h %h %h %h", fWrite, fAddr, fWdata, fRdata, fHit, fErr);
			if (n != 6) begin
				errCount++;
				$display("vector line could not be parsed: %s", line);
			end else begin
				v = '{fWrite[0], fAddr[15:0], fWdata[15:0], fRdata[15:0], fHit[0], fErr[0]};
				vecQ.push_back(v);
			end
		end
		$fclose(fd);
	endtask

	// Holds the request until it transfers, returns a short delay after that edge
	task automatic driveRequest(input vecLine_t v, input int idx);
		logic taken;
		int acceptCyc;
		pending_t p;
		req = '{write: v.write, addr: v.addr, wdata: v.wdata};
		reqValid = 1'b1;
		taken = 1'b0;
		acceptCyc = 0;
		while (!taken) begin
			taken = reqReady;
			acceptCyc = cycleCount;
			@(posedge clk);
			#DRIVE_DELAY;
		end
		p = '{vec: v, idx: idx, acceptCyc: acceptCyc};
		pendQ.push_back(p);
		reqValid = 1'b0;
	endtask

	initial begin
		int gap;
		clk = 1'b0;
		rstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		void'($urandom(32'hbabe));
		loadVectors();
		timeoutLimit = vecQ.size() * CYCLES_PER_VEC + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rstN = 1'b1;
		compareValue("reqReady after reset", reqReady, 1'b1);
		compareValue("rspValid after reset", rspValid, 1'b0);
		compareValue("memReqValid after reset", i_dut.memReqValid, 1'b0);
		foreach (vecQ[i]) begin
			driveRequest(vecQ[i], i);
			gap = $urandom % 4;  // Idle cycles before the next request
			repeat (gap) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
		end
		while (pendQ.size() > 0) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		@(posedge clk);  // One more cycle to catch a stray response
		#DRIVE_DELAY;
		compareValue("accepted requests", acceptCount, vecQ.size());
		compareValue("responses", rspCount, vecQ.size());
		$display("Summary: %0d vectors, %0d checks, %0d errors", vecQ.size(), checkCount,
			errCount);
		if (errCount == 0 && vecQ.size() > 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- memSystem.sv
`timescale 1ns/1ns

module memSystem (
	input  logic clk,
	input  logic rstN,
	input  logic reqValid,
	output logic reqReady,
	input  cachePkg::cpuReq_t req,
	output logic rspValid,
	output cachePkg::cpuRsp_t rsp
);

	cachePkg::wayCmd_t wayCmd;
	cachePkg::wayStat_t stat0;
	cachePkg::wayStat_t stat1;
	logic wayWrite0;
	logic wayWrite1;
	logic memReqValid;
	logic memReqReady;
	logic memRspValid;
	memPkg::memReq_t memReq;
	memPkg::memRsp_t memRsp;

	cacheCtrl i_ctrl (
		.clk         (clk),
		.rstN        (rstN),
		.reqValid    (reqValid),
		.reqReady    (reqReady),
		.req         (req),
		.rspValid    (rspValid),
		.rsp         (rsp),
		.wayCmd      (wayCmd),
		.wayWrite0   (wayWrite0),
		.wayWrite1   (wayWrite1),
		.stat0       (stat0),
		.stat1       (stat1),
		.memReqValid (memReqValid),
		.memReqReady (memReqReady),
		.memReq      (memReq),
		.memRspValid (memRspValid),
		.memRsp      (memRsp)
	);

	// Both ways see the same command, each with its own write strobe
	cacheWay #(.WAY_ID(0)) i_way0 (
		.clk      (clk),
		.rstN     (rstN),
		.cmd      (wayCmd),
		.wayWrite (wayWrite0),
		.stat     (stat0)
	);

	cacheWay #(.WAY_ID(1)) i_way1 (
		.clk      (clk),
		.rstN     (rstN),
		.cmd      (wayCmd),
		.wayWrite (wayWrite1),
		.stat     (stat1)
	);

	bankedMem i_mem (
		.clk         (clk),
		.rstN        (rstN),
		.memReqValid (memReqValid),
		.memReqReady (memReqReady),
		.memReq      (memReq),
		.memRspValid (memRspValid),
		.memRsp      (memRsp)
	);

endmodule

//--- bankedMem.sv
`timescale 1ns/1ns
`include "memSystem_macros.svh"

module bankedMem (
	input  logic clk,
	input  logic rstN,
	input  logic memReqValid,
	output logic memReqReady,
	input  memPkg::memReq_t memReq,
	output logic memRspValid,
	output memPkg::memRsp_t memRsp
);

	localparam int BANKS = 4;
	localparam int ROW_W = $bits(memPkg::memAddr_t) - 2;
	localparam int TIMER_W = $clog2(`BANK_BUSY + 1);

	cachePkg::word_t bankArr [BANKS][2**ROW_W];
	logic [TIMER_W-1:0] busyTimer [BANKS];
	logic [`MEM_READ_LAT-1:0] pipeValid;
	memPkg::memRsp_t pipeRsp [`MEM_READ_LAT];
	logic [1:0] bankSel;
	logic [ROW_W-1:0] rowSel;
	logic accept;
	logic [BANKS-1:0] bankAcc;

	assign bankSel = memReq.addr[1:0];  // Consecutive words hit different banks
	assign rowSel = memReq.addr[ROW_W+1:2];
	assign memReqReady = (busyTimer[bankSel] == '0);
	assign accept = memReqValid && memReqReady;

	always_comb begin
		for (int b = 0; b < BANKS; b++) begin
			bankAcc[b] = accept && (bankSel == b[1:0]);
		end
	end

	initial begin
		// Each word starts out holding its own byte address
		for (int b = 0; b < BANKS; b++) begin
			for (int r = 0; r < 2**ROW_W; r++) begin
				bankArr[b][r] = cachePkg::word_t'({r[ROW_W-1:0], b[1:0], 1'b0});
			end
		end
	end

	always @(posedge clk) begin
		if (accept && memReq.write) begin
			bankArr[bankSel][rowSel] <= memReq.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int b = 0; b < BANKS; b++) begin
				busyTimer[b] <= '0;
			end
		end else begin
			for (int b = 0; b < BANKS; b++) begin
				if (bankAcc[b]) begin
					busyTimer[b] <= TIMER_W'(`BANK_BUSY);
				end else if (busyTimer[b] != '0) begin
					busyTimer[b] <= busyTimer[b] - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pipeValid <= '0;
		end else begin
			// Only reads answer
			pipeValid <= {pipeValid[`MEM_READ_LAT-2:0], accept && !memReq.write};
		end
	end

	always_ff @(posedge clk) begin
		pipeRsp[0] <= '{rdata: bankArr[bankSel][rowSel], addr: memReq.addr};
		for (int s = 1; s < `MEM_READ_LAT; s++) begin
			pipeRsp[s] <= pipeRsp[s-1];
		end
	end

	assign memRspValid = pipeValid[`MEM_READ_LAT-1];
	assign memRsp = pipeRsp[`MEM_READ_LAT-1];

	// A bank stays closed for BANK_BUSY cycles after each acceptance
	for (genvar b = 0; b < BANKS; b++) begin : gBankChk
		for (genvar lag = 1; lag <= `BANK_BUSY; lag++) begin : gLag
			assert property (@(posedge clk) disable iff (!rstN)
				bankAcc[b] |-> !$past(bankAcc[b], lag))
				else $error("bankedMem: bank %0d accepted while busy", b);
		end
	end

endmodule

//--- cacheCtrl.sv
`timescale 1ns/1ns
`include "memSystem_macros.svh"

module cacheCtrl (
	input  logic clk,
	input  logic rstN,
	input  logic reqValid,
	output logic reqReady,
	input  cachePkg::cpuReq_t req,
	output logic rspValid,
	output cachePkg::cpuRsp_t rsp,
	output cachePkg::wayCmd_t wayCmd,
	output logic wayWrite0,
	output logic wayWrite1,
	input  cachePkg::wayStat_t stat0,
	input  cachePkg::wayStat_t stat1,
	output logic memReqValid,
	input  logic memReqReady,
	output memPkg::memReq_t memReq,
	input  logic memRspValid,
	input  memPkg::memRsp_t memRsp
);

	cachePkg::ctrlState_t state;
	cachePkg::cpuReq_t reqReg;
	cachePkg::wayStat_t curStat;
	cachePkg::tag_t memTag;
	logic [2**`INDEX_W-1:0] lruBits;  // Per set, the way to evict next
	logic [2:0] reqCnt;  // Memory requests accepted so far
	logic [1:0] rspCnt;  // Fill words returned so far
	logic firstLook;  // First compare of this access decides the hit flag
	logic hitReg;
	logic errReg;
	logic wayReg;  // Way serving the current access
	logic hitAny;
	logic hitWay;
	logic victimWay;
	logic victimDirty;
	logic inFill;
	logic cmpWrite;
	logic fillWrite;

	assign hitAny = stat0.hit || stat1.hit;
	assign hitWay = !stat0.hit;
	assign inFill = (state == cachePkg::stFill);

	// Invalid way first, way 0 when both are free, else LRU
	always_comb begin
		if (!stat0.valid) begin
			victimWay = 1'b0;
		end else if (!stat1.valid) begin
			victimWay = 1'b1;
		end else begin
			victimWay = lruBits[reqReg.addr.index];
		end
	end

	assign victimDirty = victimWay ? stat1.dirty : stat0.dirty;
	assign curStat = wayReg ? stat1 : stat0;

	// Compare writes go to the hit way, fill writes to the victim
	assign cmpWrite = (state == cachePkg::stCompare) && reqReg.write;
	assign fillWrite = inFill && memRspValid;
	assign wayWrite0 = (cmpWrite && stat0.hit) || (fillWrite && !wayReg);
	assign wayWrite1 = (cmpWrite && stat1.hit) || (fillWrite && wayReg);

	always_comb begin
		wayCmd.index = reqReg.addr.index;
		wayCmd.tag = reqReg.addr.tag;
		wayCmd.fill = inFill;
		wayCmd.validIn = inFill;
		wayCmd.wdata = inFill ? memRsp.rdata : reqReg.wdata;
		wayCmd.wrEn = {wayWrite1, wayWrite0};
		case (state)
			cachePkg::stWriteback: wayCmd.offset = reqCnt[1:0];  // Victim word going out
			cachePkg::stFill: wayCmd.offset = memRsp.addr[1:0];  // Word just returned
			default: wayCmd.offset = reqReg.addr.offset;
		endcase
	end

	assign reqReady = (state == cachePkg::stIdle);
	assign rspValid = (state == cachePkg::stFinish);
	assign rsp = '{rdata: curStat.rdata, hit: hitReg, err: errReg};

	// Writeback uses the victim's tag, fill the requested one
	assign memTag = (state == cachePkg::stWriteback) ? curStat.tag : reqReg.addr.tag;
	assign memReqValid = (state == cachePkg::stWriteback) || (inFill && !reqCnt[2]);
	assign memReq = '{
		write: (state == cachePkg::stWriteback),
		addr: {memTag, reqReg.addr.index, reqCnt[1:0]},
		wdata: curStat.rdata
	};

	always_ff @(posedge clk) begin
		if (reqValid && reqReady) begin
			reqReg <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= cachePkg::stIdle;
			lruBits <= '0;
			reqCnt <= '0;
			rspCnt <= '0;
			firstLook <= 1'b0;
			hitReg <= 1'b0;
			errReg <= 1'b0;
			wayReg <= 1'b0;
		end else begin
			case (state)
				cachePkg::stIdle: begin
					if (reqValid) begin
						firstLook <= 1'b1;
						hitReg <= 1'b0;
						errReg <= req.addr.byteSel;
						// Misaligned goes straight to the response
						state <= req.addr.byteSel ? cachePkg::stFinish : cachePkg::stCompare;
					end
				end
				cachePkg::stCompare: begin
					firstLook <= 1'b0;
					reqCnt <= '0;
					rspCnt <= '0;
					if (firstLook) begin
						hitReg <= hitAny;
					end
					if (hitAny) begin
						wayReg <= hitWay;
						state <= cachePkg::stFinish;
					end else begin
						wayReg <= victimWay;
						state <= victimDirty ? cachePkg::stWriteback : cachePkg::stFill;
					end
				end
				cachePkg::stWriteback: begin
					if (memReqReady) begin
						if (reqCnt[1:0] == 2'd3) begin
							reqCnt <= '0;
							state <= cachePkg::stFill;
						end else begin
							reqCnt <= reqCnt + 3'd1;
						end
					end
				end
				cachePkg::stFill: begin
					if (memReqValid && memReqReady) begin
						reqCnt <= reqCnt + 3'd1;
					end
					if (memRspValid) begin
						rspCnt <= rspCnt + 2'd1;
						if (rspCnt == 2'd3) begin
							state <= cachePkg::stCompare;  // Rerun lookup, now a hit
						end
					end
				end
				cachePkg::stFinish: begin
					if (!errReg) begin
						lruBits[reqReg.addr.index] <= !wayReg;
					end
					state <= cachePkg::stIdle;
				end
				default: state <= cachePkg::stIdle;
			endcase
		end
	end

	// An accepted request blocks the port until its response
	assert property (@(posedge clk) disable iff (!rstN)
		(reqValid && reqReady) |=> !reqReady)
		else $error("cacheCtrl: reqReady high right after acceptance");

	assert property (@(posedge clk) disable iff (!rstN)
		rspValid |=> !rspValid)
		else $error("cacheCtrl: rspValid held for two cycles");

	assert property (@(posedge clk) disable iff (!rstN)
		!(wayWrite0 && wayWrite1))
		else $error("cacheCtrl: both ways written in one cycle");

endmodule

//--- cacheWay.sv
`timescale 1ns/1ns
`include "memSystem_macros.svh"

module cacheWay #(
	parameter int WAY_ID = 0
) (
	input  logic clk,
	input  logic rstN,
	input  cachePkg::wayCmd_t cmd,
	input  logic wayWrite,
	output cachePkg::wayStat_t stat
);

	localparam int SETS = 2**`INDEX_W;
	localparam int OFFSET_W = $clog2(`LINE_WORDS);

	cachePkg::tag_t tagArr [SETS];
	cachePkg::word_t dataArr [SETS*`LINE_WORDS];
	logic [SETS-1:0] validBits;
	logic [SETS-1:0] dirtyBits;
	logic [`INDEX_W+OFFSET_W-1:0] wordSel;

	assign wordSel = {cmd.index, cmd.offset};  // Flat word index into the data array

	always_comb begin
		stat.valid = validBits[cmd.index];
		stat.tag = tagArr[cmd.index];
		stat.dirty = validBits[cmd.index] && dirtyBits[cmd.index];  // Stale dirty hidden
		stat.hit = stat.valid && (stat.tag == cmd.tag);
		stat.rdata = dataArr[wordSel];
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			validBits <= '0;
			dirtyBits <= '0;
		end else if (wayWrite) begin
			if (cmd.fill) begin
				validBits[cmd.index] <= cmd.validIn;
				dirtyBits[cmd.index] <= 1'b0;  // Line now matches memory
			end else begin
				dirtyBits[cmd.index] <= 1'b1;  // CPU write on a hit
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wayWrite) begin
			dataArr[wordSel] <= cmd.wdata;
			if (cmd.fill) begin
				tagArr[cmd.index] <= cmd.tag;
			end
		end
	end

	// The top must route each controller enable to the matching instance
	assert property (@(posedge clk) disable iff (!rstN)
		wayWrite == cmd.wrEn[WAY_ID])
		else $error("cacheWay %0d: write strobe does not match command enable", WAY_ID);

endmodule

//--- memPkg.sv
`include "memSystem_macros.svh"

package memPkg;

	// Word address, the byte bit dropped
	typedef logic [`TAG_W+`INDEX_W+$clog2(`LINE_WORDS)-1:0] memAddr_t;

	typedef struct packed {
		logic write;
		memAddr_t addr;
		cachePkg::word_t wdata;
	} memReq_t;

	typedef struct packed {
		cachePkg::word_t rdata;
		memAddr_t addr;  // Lets the requester place the word
	} memRsp_t;

endpackage

//--- cachePkg.sv
`include "memSystem_macros.svh"

package cachePkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`TAG_W-1:0] tag_t;
	typedef logic [`INDEX_W-1:0] index_t;
	typedef logic [$clog2(`LINE_WORDS)-1:0] offset_t;

	// Byte address as the cache sees it
	typedef struct packed {
		tag_t tag;
		index_t index;
		offset_t offset;
		logic byteSel;  // Must be zero for a word access
	} addr_t;

	typedef struct packed {
		logic write;
		addr_t addr;
		word_t wdata;
	} cpuReq_t;

	typedef struct packed {
		word_t rdata;
		logic hit;
		logic err;
	} cpuRsp_t;

	typedef enum logic [2:0] {
		stIdle,
		stCompare,
		stWriteback,
		stFill,
		stFinish
	} ctrlState_t;

	// Shared by both ways, only the way's own write enable differs
	typedef struct packed {
		index_t index;
		offset_t offset;
		tag_t tag;
		word_t wdata;
		logic [1:0] wrEn;  // Bit n enables way n
		logic fill;
		logic validIn;
	} wayCmd_t;

	typedef struct packed {
		logic hit;
		logic valid;
		logic dirty;
		tag_t tag;
		word_t rdata;
	} wayStat_t;

endpackage

//--- memSystem_macros.svh
`ifndef MEMSYSTEM_MACROS_SVH
`define MEMSYSTEM_MACROS_SVH

// Datapath and address geometry
`define WORD_W 16
`define TAG_W 5
`define INDEX_W 8
`define LINE_WORDS 4

// Main memory timing in cycles
`define MEM_READ_LAT 2
`define BANK_BUSY 4

`endif
